//--- logic/trace_pkg.sv
package trace_pkg;

  //////////////////////////////////////////////////
  // trace frame geometry
  //////////////////////////////////////////////////

  localparam int XLEN         = 32;   // pc and gpr width, one stream word
  localparam int RECORD_WORDS = 5;    // hdr, pc, instr, rd info, rd value
  localparam int SEQ_W        = 16;   // lower half of the header word
  localparam int WORD_SEL_W   = $clog2(RECORD_WORDS);

  localparam logic [15:0] TRACE_MAGIC = 16'h5256;   // "RV" in the upper half

  // word positions inside one frame
  localparam logic [WORD_SEL_W-1:0] W_HDR   = 3'd0;
  localparam logic [WORD_SEL_W-1:0] W_PC    = 3'd1;
  localparam logic [WORD_SEL_W-1:0] W_INSTR = 3'd2;
  localparam logic [WORD_SEL_W-1:0] W_RD    = 3'd3;  // wen and addr packed low
  localparam logic [WORD_SEL_W-1:0] W_VALUE = 3'd4;  // carries last

  localparam int RD_INFO_W = 6;   // gpr_wen + gpr_addr

  //////////////////////////////////////////////////
  // retire buffer sizing
  //////////////////////////////////////////////////

  localparam int BUF_DEPTH = 2;   // power of two, pointers wrap
  localparam int PTR_W     = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W     = $clog2(BUF_DEPTH + 1);

  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(BUF_DEPTH);

  // one retired instruction as seen by the tap
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;      // raw encoding
    logic            gpr_wen;
    logic [4:0]      gpr_addr;
    logic [XLEN-1:0] gpr_value;  // write data, meaningful when gpr_wen
  } retire_t;  // 102 bits

endpackage

//--- logic/link_pkg.sv
package link_pkg;

  //////////////////////////////////////////////////
  // word stream
  //////////////////////////////////////////////////

  localparam int WORD_W = 32;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              last;   // final word of a frame
  } beat_t;  // 33 bits

  localparam int IDX_W = 3;
  localparam logic [IDX_W-1:0] IDX_MAX = '1;   // index sticks here

  typedef struct packed {
    beat_t            beat;
    logic [IDX_W-1:0] idx;     // position within the frame
  } indexed_beat_t;  // 36 bits

  //////////////////////////////////////////////////
  // host command frames
  //////////////////////////////////////////////////

  localparam int CMD_WORDS = 5;
  localparam logic [IDX_W-1:0] CMD_LAST_IDX = 3'd4;  // last word of the string
  localparam logic [IDX_W-1:0] ARG_IDX      = 3'd5;  // optional argument word

  localparam int NUM_CMDS    = 2;
  localparam int CMD_TRIGGER = 0;
  localparam int CMD_SLOW    = 1;

  // word 0 arrives first: dst mac low, mac words, ether type 005c with tag
  localparam logic [WORD_W-1:0] CMD_STRINGS [NUM_CMDS][CMD_WORDS] = '{
    '{32'h1111_6843, 32'h1654_4502, 32'h8f54_0000, 32'h7274_005c, 32'h6e69_6769},  // trigin
    '{32'h1111_6843, 32'h1654_4502, 32'h8f54_0000, 32'h6c73_005c, 32'h656d_776f}   // slowme
  };

  typedef struct packed {
    logic              hit;   // one cycle per matching frame
    logic [WORD_W-1:0] arg;   // word 5, zero if absent
  } cmd_hit_t;  // 33 bits

endpackage

//--- logic/trace_packetizer.sv
`timescale 1ns/100ps

module trace_packetizer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               retire_valid,
  input  trace_pkg::retire_t retire,
  input  logic               ext_stall,     // core sees this, no accept while high
  output logic               trace_stall,
  output logic               tx_valid,
  output link_pkg::beat_t    tx_beat,
  input  logic               tx_ready
);

  //////////////////////////////////////////////////
  // record buffer
  //////////////////////////////////////////////////

  trace_pkg::retire_t mem [trace_pkg::BUF_DEPTH];

  logic [trace_pkg::PTR_W-1:0]      wr_ptr;
  logic [trace_pkg::PTR_W-1:0]      rd_ptr;
  logic [trace_pkg::CNT_W-1:0]      count;      // records held
  logic [trace_pkg::SEQ_W-1:0]      seq;        // seq of the head record
  logic [trace_pkg::WORD_SEL_W-1:0] word_sel;   // word now on the wire
  trace_pkg::retire_t               head;

  logic push;
  logic pop;
  logic beat_done;
  logic frame_end;

  assign push      = retire_valid & ~ext_stall;   // accepted retire
  assign beat_done = tx_valid & tx_ready;
  assign frame_end = (word_sel == trace_pkg::W_VALUE);
  assign pop       = beat_done & frame_end;       // record leaves after word 4

  assign trace_stall = (count == trace_pkg::CNT_FULL);
  assign tx_valid    = (count != '0);
  assign head        = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= retire;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // frame sequencing
  //////////////////////////////////////////////////

  // frames leave in accept order, so counting sent frames
  // gives the sequence of the head record
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seq      <= '0;
      word_sel <= trace_pkg::W_HDR;
    end else if (beat_done) begin
      if (frame_end) begin
        word_sel <= trace_pkg::W_HDR;
        seq      <= seq + 1'b1;
      end else begin
        word_sel <= word_sel + 1'b1;
      end
    end
  end

  // word mux, held stable while tx_ready is low
  always_comb begin
    tx_beat.last = frame_end;
    case (word_sel)
      trace_pkg::W_HDR:   tx_beat.data = {trace_pkg::TRACE_MAGIC, seq};
      trace_pkg::W_PC:    tx_beat.data = head.pc;
      trace_pkg::W_INSTR: tx_beat.data = head.instr;
      trace_pkg::W_RD: begin
        // bit 5 wen, bits 4:0 rd
        tx_beat.data = {{(link_pkg::WORD_W - trace_pkg::RD_INFO_W){1'b0}},
                        head.gpr_wen, head.gpr_addr};
      end
      default:            tx_beat.data = head.gpr_value;
    endcase
  end

endmodule

//--- logic/rx_word_indexer.sv
`timescale 1ns/100ps

module rx_word_indexer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx_valid,   // no backpressure on rx
  input  link_pkg::beat_t         rx_beat,
  output logic                    ib_valid,
  output link_pkg::indexed_beat_t ib
);

  //////////////////////////////////////////////////
  // position tracking
  //////////////////////////////////////////////////

  logic [link_pkg::IDX_W-1:0] pos;   // index of the next rx word

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pos      <= '0;
      ib_valid <= 1'b0;
    end else begin
      ib_valid <= rx_valid;
      if (rx_valid) begin
        if (rx_beat.last) begin
          pos <= '0;                       // next frame starts fresh
        end else if (pos != link_pkg::IDX_MAX) begin
          pos <= pos + 1'b1;               // saturate, long tails stay at 7
        end
      end
    end
  end

  // registered word plus its index, one cycle behind rx
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      ib.beat <= rx_beat;
      ib.idx  <= pos;
    end
  end

endmodule

//--- logic/cmd_frame_matcher.sv
`timescale 1ns/100ps

module cmd_frame_matcher #(
  parameter int CMD = link_pkg::CMD_TRIGGER   // row of the command table
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ib_valid,
  input  link_pkg::indexed_beat_t ib,
  output link_pkg::cmd_hit_t      hit_out
);

  logic [link_pkg::IDX_W-1:0]  cmp_idx;    // kept inside the table
  logic                        in_string;  // word lies in the command string
  logic                        word_bad;
  logic                        bad_q;      // some earlier word differed
  logic                        bad_now;
  logic                        long_enough;
  logic                        frame_end;
  logic [link_pkg::WORD_W-1:0] arg_q;      // word 5 once seen, else zero
  logic [link_pkg::WORD_W-1:0] arg_now;
  logic                        hit_q;
  logic [link_pkg::WORD_W-1:0] hit_arg;

  always_comb begin
    in_string   = (ib.idx < link_pkg::CMD_WORDS);
    cmp_idx     = in_string ? ib.idx : '0;
    word_bad    = in_string && (ib.beat.data != link_pkg::CMD_STRINGS[CMD][cmp_idx]);
    bad_now     = bad_q | word_bad;
    long_enough = (ib.idx >= link_pkg::CMD_LAST_IDX);   // at least 5 words
    // argument may be the last word itself
    arg_now     = (ib.idx == link_pkg::ARG_IDX) ? ib.beat.data : arg_q;
  end

  assign frame_end = ib_valid & ib.beat.last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bad_q <= 1'b0;
      arg_q <= '0;
      hit_q <= 1'b0;
    end else begin
      hit_q <= frame_end & ~bad_now & long_enough;   // single cycle
      if (frame_end) begin
        bad_q <= 1'b0;                               // clear for next frame
        arg_q <= '0;
      end else if (ib_valid) begin
        bad_q <= bad_now;
        if (ib.idx == link_pkg::ARG_IDX) arg_q <= ib.beat.data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_end) hit_arg <= arg_now;
  end

  assign hit_out = '{hit: hit_q, arg: hit_arg};

endmodule

//--- logic/host_stall_ctrl.sv
`timescale 1ns/100ps

module host_stall_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  link_pkg::cmd_hit_t hits [link_pkg::NUM_CMDS],   // one per command row
  output logic               trigger,
  output logic               host_stall
);

  //////////////////////////////////////////////////
  // debug trigger
  //////////////////////////////////////////////////

  // already a one-cycle pulse from the matcher
  assign trigger = hits[link_pkg::CMD_TRIGGER].hit;

  //////////////////////////////////////////////////
  // slow-down countdown
  //////////////////////////////////////////////////

  logic                        slow_hit;
  logic [link_pkg::WORD_W-1:0] slow_arg;    // requested stall cycles
  logic [link_pkg::WORD_W-1:0] left;        // cycles still owed after this one

  assign slow_hit = hits[link_pkg::CMD_SLOW].hit;
  assign slow_arg = hits[link_pkg::CMD_SLOW].arg;

  // hit cycle itself stalls, so the counter loads N-1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      left <= '0;
    end else if (slow_hit) begin
      left <= (slow_arg != '0) ? slow_arg - 1'b1 : '0;   // reload, zero means none
    end else if (left != '0) begin
      left <= left - 1'b1;
    end
  end

  // stall begins with the hit, same cycle a trigger would show
  assign host_stall = slow_hit ? (slow_arg != '0) : (left != '0);

endmodule

//--- logic/trace_tap.sv
`timescale 1ns/100ps

module trace_tap (
  input  logic               clk,
  input  logic               rst_n,
  // retire port from the core
  input  logic               retire_valid,
  input  trace_pkg::retire_t retire,
  output logic               ext_stall,
  // trace frames out
  output logic               tx_valid,
  output link_pkg::beat_t    tx_beat,
  input  logic               tx_ready,
  // host commands in, always accepted
  input  logic               rx_valid,
  input  link_pkg::beat_t    rx_beat,
  output logic               trigger
);

  logic                    trace_stall;   // buffer full
  logic                    host_stall;    // host asked for slow-down
  logic                    ib_valid;
  link_pkg::indexed_beat_t ib;
  link_pkg::cmd_hit_t      hits [link_pkg::NUM_CMDS];

  //////////////////////////////////////////////////
  // tx path
  //////////////////////////////////////////////////

  trace_packetizer u_packetizer (
    .clk          (clk),
    .rst_n        (rst_n),
    .retire_valid (retire_valid),
    .retire       (retire),
    .ext_stall    (ext_stall),
    .trace_stall  (trace_stall),
    .tx_valid     (tx_valid),
    .tx_beat      (tx_beat),
    .tx_ready     (tx_ready)
  );

  //////////////////////////////////////////////////
  // rx path
  //////////////////////////////////////////////////

  rx_word_indexer u_indexer (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_valid (rx_valid),
    .rx_beat  (rx_beat),
    .ib_valid (ib_valid),
    .ib       (ib)
  );

  // one matcher per command row
  for (genvar k = 0; k < link_pkg::NUM_CMDS; k++) begin : g_cmd
    cmd_frame_matcher #(.CMD(k)) u_matcher (
      .clk      (clk),
      .rst_n    (rst_n),
      .ib_valid (ib_valid),
      .ib       (ib),
      .hit_out  (hits[k])
    );
  end

  host_stall_ctrl u_host_stall (
    .clk        (clk),
    .rst_n      (rst_n),
    .hits       (hits),
    .trigger    (trigger),
    .host_stall (host_stall)
  );

  assign ext_stall = trace_stall | host_stall;   // either side holds the core

endmodule

//--- sim/tb_trace_tap.sv
`timescale 1ns/100ps

module tb_trace_tap;

  localparam int NSTEPS      = 11;
  localparam int OBS_CYCLES  = 12;   // window after an rx frame
  localparam int ACCEPT_WAIT = 200;  // cycles a retire may be held
  localparam int DRAIN_WAIT  = 400;

  typedef enum int {K_RETIRE, K_RX, K_IDLE} step_kind_t;

  logic               clk;
  logic               rst_n;
  logic               retire_valid;
  trace_pkg::retire_t retire;
  logic               ext_stall;
  logic               tx_valid;
  link_pkg::beat_t    tx_beat;
  logic               tx_ready;
  logic               rx_valid;
  link_pkg::beat_t    rx_beat;
  logic               trigger;

  //////////////////////////////////////////////////
  // step table
  //////////////////////////////////////////////////

  string       step_name  [NSTEPS];
  step_kind_t  step_kind  [NSTEPS];
  int          step_len   [NSTEPS];      // retires, rx words or idle cycles
  bit          step_rand  [NSTEPS];      // random tx_ready
  bit          step_probe [NSTEPS];      // first word latency or held retire probe
  logic [31:0] step_words [NSTEPS][8];
  int          exp_trig   [NSTEPS];      // trigger cycles
  int          exp_stall  [NSTEPS];      // stall cycles or expected full buffer

  // model state
  logic [32:0] exp_q [$];                // {data, last} in wire order
  logic [15:0] seq_model;
  logic [31:0] lcg_state;
  logic [31:0] ready_rnd;
  logic        ready_next;               // tx_ready for the coming cycle
  int          accepted;
  int          frames_done;
  bit          rand_ready;
  bit          host_window;              // host stall may be active
  bit          saw_full;

  trace_tap u_trace_tap (
    .clk          (clk),
    .rst_n        (rst_n),
    .retire_valid (retire_valid),
    .retire       (retire),
    .ext_stall    (ext_stall),
    .tx_valid     (tx_valid),
    .tx_beat      (tx_beat),
    .tx_ready     (tx_ready),
    .rx_valid     (rx_valid),
    .rx_beat      (rx_beat),
    .trigger      (trigger)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  //////////////////////////////////////////////////
  // checks and failure exits
  //////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("TEST FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    stop_on_error();
  endtask

  // drawn at the falling edge, driven after the rising one
  always begin
    @(negedge clk);
    ready_rnd  = lcg_next();
    ready_next = rand_ready ? ready_rnd[16] : 1'b1;
    @(posedge clk);
    #2;
    tx_ready = ready_next;
  end

  // tx side scoreboard
  always @(negedge clk) begin : tx_monitor
    logic [32:0] exp_w;
    if (rst_n) begin
      if (!host_window) begin
        check_val("ext_stall vs buffer", (accepted - frames_done) == trace_pkg::BUF_DEPTH,
                  ext_stall);
      end
      if (tx_valid && tx_ready) begin
        if (exp_q.size() == 0) begin
          $display("tx word %h sent with no retire outstanding", tx_beat.data);
          stop_on_error();
        end else begin
          exp_w = exp_q.pop_front();
          check_val("tx data", exp_w[32:1], tx_beat.data);
          check_val("tx last", exp_w[0], tx_beat.last);   // only word 4
          if (exp_w[0]) frames_done <= frames_done + 1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus tasks start and end 2 ns after a rising edge
  //////////////////////////////////////////////////

  task automatic make_record(output trace_pkg::retire_t rec);
    logic [31:0] r;
    r             = lcg_next();
    rec.pc        = {r[31:2], 2'b00};
    rec.instr     = lcg_next();
    r             = lcg_next();
    rec.gpr_wen   = r[0];
    rec.gpr_addr  = r[5:1];
    rec.gpr_value = lcg_next();
  endtask

  // five words per frame with the running sequence in the header
  task automatic expect_frame(input trace_pkg::retire_t rec);
    exp_q.push_back({trace_pkg::TRACE_MAGIC, seq_model, 1'b0});
    exp_q.push_back({rec.pc, 1'b0});
    exp_q.push_back({rec.instr, 1'b0});
    exp_q.push_back({26'd0, rec.gpr_wen, rec.gpr_addr, 1'b0});
    exp_q.push_back({rec.gpr_value, 1'b1});
    seq_model = seq_model + 16'd1;
    accepted <= accepted + 1;
  endtask

  task automatic send_retire(input trace_pkg::retire_t rec, input bit check_first);
    int          waited;
    logic [31:0] hdr;
    retire_valid = 1'b1;
    retire       = rec;
    waited       = 0;
    @(negedge clk);
    while (ext_stall) begin                 // core holds the record
      saw_full = 1'b1;
      waited++;
      if (waited > ACCEPT_WAIT) stop_on_timeout("retire never accepted");
      @(negedge clk);
    end
    hdr = {trace_pkg::TRACE_MAGIC, seq_model};
    expect_frame(rec);                      // taken at the coming edge
    @(posedge clk);
    #2;
    retire_valid = 1'b0;
    if (check_first) begin
      @(negedge clk);
      check_val("first word valid", 1, tx_valid);
      check_val("first word header", hdr, tx_beat.data);
      @(posedge clk);
      #2;
    end
  endtask

  task automatic send_frame(input int s);
    for (int w = 0; w < step_len[s]; w++) begin
      rx_valid     = 1'b1;
      rx_beat.data = step_words[s][w];
      rx_beat.last = (w == step_len[s] - 1);
      @(posedge clk);
      #2;
    end
    rx_valid = 1'b0;
    rx_beat  = '0;
  endtask

  // offsets count from the cycle after the last rx word
  task automatic observe(input int s);
    int                 trig_n;
    int                 trig_at;
    int                 stall_n;
    int                 stall_at;
    int                 acc_at;
    trace_pkg::retire_t rec;
    trig_n   = 0;
    trig_at  = -1;
    stall_n  = 0;
    stall_at = -1;
    acc_at   = -1;
    make_record(rec);
    for (int i = 0; i < OBS_CYCLES; i++) begin
      @(negedge clk);
      if (trigger) begin
        trig_n++;
        if (trig_at < 0) trig_at = i;
      end
      if (ext_stall) begin
        stall_n++;
        if (stall_at < 0) stall_at = i;
      end
      if (retire_valid && !ext_stall && acc_at < 0) begin
        expect_frame(rec);
        acc_at = i;
      end
      @(posedge clk);
      #2;
      if (acc_at >= 0) begin
        retire_valid = 1'b0;
      end else if (step_probe[s] && stall_at >= 0) begin
        retire_valid = 1'b1;                // offered while stalled
        retire       = rec;
      end
    end
    check_val({step_name[s], " trigger cycles"}, exp_trig[s], trig_n);
    if (exp_trig[s] > 0) check_val({step_name[s], " trigger delay"}, 1, trig_at);
    check_val({step_name[s], " stall cycles"}, exp_stall[s], stall_n);
    if (exp_stall[s] > 0) check_val({step_name[s], " stall start"}, 1, stall_at);
    if (step_probe[s]) check_val({step_name[s], " held retire"}, stall_at + stall_n, acc_at);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || tx_valid) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > DRAIN_WAIT) stop_on_timeout("tx frames never drained");
    end
  endtask

  task automatic set_step(input int s, input string name, input step_kind_t kind,
                          input int len, input bit rnd, input bit probe,
                          input int trig, input int stall);
    step_name[s]  = name;
    step_kind[s]  = kind;
    step_len[s]   = len;
    step_rand[s]  = rnd;
    step_probe[s] = probe;
    exp_trig[s]   = trig;
    exp_stall[s]  = stall;
  endtask

  // command string, argument, then one tail word
  task automatic set_frame(input int s, input int cmd, input logic [31:0] arg);
    for (int w = 0; w < link_pkg::CMD_WORDS; w++) begin
      step_words[s][w] = link_pkg::CMD_STRINGS[cmd][w];
    end
    step_words[s][5] = arg;
    step_words[s][6] = 32'h7a11_0006;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    trace_pkg::retire_t rec;
    rst_n        = 1'b0;
    retire_valid = 1'b0;
    retire       = '0;
    rx_valid     = 1'b0;
    rx_beat      = '0;
    tx_ready     = 1'b1;
    ready_next   = 1'b1;
    lcg_state    = 32'h9ad6;
    seq_model    = 16'd0;
    accepted     = 0;
    frames_done  = 0;
    rand_ready   = 1'b0;
    host_window  = 1'b0;
    saw_full     = 1'b0;

    set_step(0,  "after reset",     K_IDLE,   3, 0, 0, 0, 0);
    set_step(1,  "single retire",   K_RETIRE, 1, 0, 1, 0, 0);
    set_step(2,  "retire burst",    K_RETIRE, 8, 1, 0, 0, 1);
    set_step(3,  "trigger",         K_RX,     5, 0, 0, 1, 0);
    set_step(4,  "trigger bad",     K_RX,     5, 0, 0, 0, 0);
    set_step(5,  "trigger short",   K_RX,     4, 0, 0, 0, 0);
    set_step(6,  "slow 6",          K_RX,     6, 0, 1, 0, 6);
    set_step(7,  "slow no arg",     K_RX,     5, 0, 0, 0, 0);
    set_step(8,  "trigger tail",    K_RX,     7, 0, 0, 1, 0);
    set_step(9,  "retire tail",     K_RETIRE, 3, 1, 0, 0, 0);
    set_step(10, "idle end",        K_IDLE,   3, 0, 0, 0, 0);
    set_frame(3, link_pkg::CMD_TRIGGER, 32'd0);
    set_frame(4, link_pkg::CMD_TRIGGER, 32'd0);
    step_words[4][2] ^= 32'h0000_0100;      // one flipped bit in word 2
    set_frame(5, link_pkg::CMD_TRIGGER, 32'd0);
    set_frame(6, link_pkg::CMD_SLOW, 32'd6);
    set_frame(7, link_pkg::CMD_SLOW, 32'd6);
    set_frame(8, link_pkg::CMD_TRIGGER, 32'd3);

    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int s = 0; s < NSTEPS; s++) begin
      case (step_kind[s])
        K_RETIRE: begin
          rand_ready = step_rand[s];
          saw_full   = 1'b0;
          for (int n = 0; n < step_len[s]; n++) begin
            make_record(rec);
            send_retire(rec, step_probe[s]);
          end
          wait_drain();
          rand_ready = 1'b0;
          if (exp_stall[s] != 0) check_val({step_name[s], " buffer full"}, 1, saw_full);
        end
        K_RX: begin
          host_window = (exp_stall[s] != 0);
          send_frame(s);
          observe(s);
          wait_drain();
          host_window = 1'b0;
        end
        default: begin
          for (int c = 0; c < step_len[s]; c++) begin
            @(negedge clk);
            check_val({step_name[s], " tx_valid"}, 0, tx_valid);
            check_val({step_name[s], " trigger"}, 0, trigger);
            check_val({step_name[s], " ext_stall"}, 0, ext_stall);
            @(posedge clk);
            #2;
          end
        end
      endcase
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- trace_tap.f
logic/trace_pkg.sv
logic/link_pkg.sv
logic/trace_packetizer.sv
logic/rx_word_indexer.sv
logic/cmd_frame_matcher.sv
logic/host_stall_ctrl.sv
logic/trace_tap.sv
sim/tb_trace_tap.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f trace_tap.f --top-module tb_trace_tap -o tb_trace_tap ||
  exit 1
out=$(./obj_dir/tb_trace_tap 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST PASS" && exit 0 || exit 1
